/* hdl/cache_pkg.sv */
// Cache sizes, request opcodes, ack types, controller states and the address union
package cache_pkg;

  localparam int ways           = 4;
  localparam int sets           = 16;
  localparam int index_w        = 4;
  localparam int words_per_line = 4;
  localparam int word_sel_w     = 2;
  localparam int byte_w         = 2;  // Byte offset, ignored by the lookup
  localparam int tag_w          = 24;
  localparam int age_w          = 2;
  localparam int state_w        = 3;

  typedef logic [31:0] word_t;
  typedef word_t [words_per_line-1:0] line_t;
  typedef logic [1:0] way_t;
  typedef logic [1:0] op_t;
  typedef logic [1:0] ack_t;

  localparam op_t op_read  = 2'b01;
  localparam op_t op_write = 2'b10;
  localparam op_t op_fill  = 2'b11;

  localparam ack_t ack_fetch = 2'b00;
  localparam ack_t ack_read  = 2'b01;
  localparam ack_t ack_write = 2'b10;
  localparam ack_t ack_wb    = 2'b11;

  // Request access FSM
  localparam logic [state_w-1:0] st_idle       = 3'd0;
  localparam logic [state_w-1:0] st_lookup     = 3'd1;
  localparam logic [state_w-1:0] st_hit_ack    = 3'd2;
  localparam logic [state_w-1:0] st_write_back = 3'd3;
  localparam logic [state_w-1:0] st_fetch      = 3'd4;
  localparam logic [state_w-1:0] st_fill_wait  = 3'd5;
  localparam logic [state_w-1:0] st_install    = 3'd6;
  localparam logic [state_w-1:0] st_miss_ack   = 3'd7;

  typedef union packed {
    word_t raw;
    struct packed {
      logic [tag_w-1:0]      tag;
      logic [index_w-1:0]    index;
      logic [word_sel_w-1:0] word_sel;
      logic [byte_w-1:0]     byte_off;
    } f;
  } addr_u;

endpackage

/* hdl/cache_ifs.sv */
// Tag array and data array interfaces between the controller and the arrays
`timescale 1ns/1ps

////////////////////////////////////////
// Tag lookup and update
////////////////////////////////////////
interface tag_if;
  logic                           lookup;
  cache_pkg::addr_u               lookup_addr;
  logic                           update;       // LRU touch on a hit
  cache_pkg::way_t                update_way;
  logic                           set_dirty;
  logic                           install;      // New tag into the victim way
  logic                           hit;
  cache_pkg::way_t                hit_way;
  cache_pkg::way_t                victim_way;
  logic                           victim_dirty;
  logic [cache_pkg::tag_w-1:0]    victim_tag;

  modport ctrl (
    output lookup, lookup_addr, update, update_way, set_dirty, install,
    input  hit, hit_way, victim_way, victim_dirty, victim_tag
  );
  modport array (
    input  lookup, lookup_addr, update, update_way, set_dirty, install,
    output hit, hit_way, victim_way, victim_dirty, victim_tag
  );
endinterface

////////////////////////////////////////
// Line storage access
////////////////////////////////////////
interface data_if;
  logic                             rd;
  logic [cache_pkg::index_w-1:0]    index;
  logic [cache_pkg::word_sel_w-1:0] word_sel;
  cache_pkg::way_t                  way;
  logic                             wr_word;
  logic                             wr_line;
  cache_pkg::word_t                 wdata;
  cache_pkg::line_t                 wline;
  cache_pkg::word_t                 rword;
  cache_pkg::line_t                 rline;

  modport ctrl (
    output rd, index, word_sel, way, wr_word, wr_line, wdata, wline,
    input  rword, rline
  );
  modport array (
    input  rd, index, word_sel, way, wr_word, wr_line, wdata, wline,
    output rword, rline
  );
endinterface

/* hdl/tag_array.sv */
// Tag, valid, dirty and LRU age storage with hit compare and victim choice
`timescale 1ns/1ps

module tag_array (
  input  logic cclk,
  input  logic cresetn,
  tag_if.array tags
);

  logic [cache_pkg::tag_w-1:0] tag_mem [cache_pkg::sets][cache_pkg::ways];
  logic [cache_pkg::ways-1:0]  valid   [cache_pkg::sets];
  logic [cache_pkg::ways-1:0]  dirty   [cache_pkg::sets];
  logic [cache_pkg::age_w-1:0] age     [cache_pkg::sets][cache_pkg::ways];

  logic [cache_pkg::index_w-1:0] idx;
  logic [cache_pkg::tag_w-1:0]   req_tag;
  logic [cache_pkg::ways-1:0]    match;
  logic                          any_match;
  cache_pkg::way_t               match_way;
  cache_pkg::way_t               victim;
  logic [cache_pkg::age_w-1:0]   old_age;
  logic                          touch;

  assign idx     = tags.lookup_addr.f.index;
  assign req_tag = tags.lookup_addr.f.tag;
  assign old_age = age[idx][tags.update_way];
  assign touch   = tags.update | tags.install;

  ////////////////////////////////////////
  // Compare and victim choice
  ////////////////////////////////////////
  always_comb begin
    match_way = '0;
    for (int w = 0; w < cache_pkg::ways; w++) begin
      match[w] = valid[idx][w] && (tag_mem[idx][w] == req_tag);
    end
    for (int w = cache_pkg::ways - 1; w >= 0; w--) begin
      if (match[w]) match_way = cache_pkg::way_t'(w);
    end
  end

  assign any_match = |match;

  always_comb begin
    victim = '0;
    for (int w = cache_pkg::ways - 1; w >= 0; w--) begin
      if (age[idx][w] == '0) victim = cache_pkg::way_t'(w);  // Least recently used
    end
    // An empty way always wins, lowest first
    for (int w = cache_pkg::ways - 1; w >= 0; w--) begin
      if (!valid[idx][w]) victim = cache_pkg::way_t'(w);
    end
  end

  ////////////////////////////////////////
  // State bits and lookup results
  ////////////////////////////////////////
  always_ff @(posedge cclk or negedge cresetn) begin
    if (!cresetn) begin
      for (int s = 0; s < cache_pkg::sets; s++) begin
        valid[s] <= '0;
        dirty[s] <= '0;
        for (int w = 0; w < cache_pkg::ways; w++) begin
          age[s][w] <= cache_pkg::age_w'(w);
        end
      end
      tags.hit          <= 1'b0;
      tags.hit_way      <= '0;
      tags.victim_way   <= '0;
      tags.victim_dirty <= 1'b0;
    end else begin
      if (tags.lookup) begin
        tags.hit          <= any_match;
        tags.hit_way      <= match_way;
        tags.victim_way   <= victim;
        tags.victim_dirty <= valid[idx][victim] && dirty[idx][victim];
      end
      if (touch) begin
        for (int w = 0; w < cache_pkg::ways; w++) begin
          if (cache_pkg::way_t'(w) == tags.update_way)
            age[idx][w] <= cache_pkg::age_w'(cache_pkg::ways - 1);  // Most recent
          else if (age[idx][w] > old_age)
            age[idx][w] <= age[idx][w] - 1'b1;
        end
      end
      if (tags.install) begin
        valid[idx][tags.update_way] <= 1'b1;
        dirty[idx][tags.update_way] <= tags.set_dirty;  // Dirty at once on a write miss
      end else if (tags.update && tags.set_dirty) begin
        dirty[idx][tags.update_way] <= 1'b1;
      end
    end
  end

  always_ff @(posedge cclk) begin
    if (tags.lookup) tags.victim_tag <= tag_mem[idx][victim];
    if (tags.install) tag_mem[idx][tags.update_way] <= req_tag;
  end

endmodule

/* hdl/data_array.sv */
// Cache line storage with set read, word write and line write
`timescale 1ns/1ps

module data_array (
  input  logic  cclk,
  data_if.array lines
);

  cache_pkg::line_t mem [cache_pkg::sets][cache_pkg::ways];
  cache_pkg::line_t rd_lines [cache_pkg::ways];  // All ways of the set read last

  ////////////////////////////////////////
  // Set read
  ////////////////////////////////////////
  always_ff @(posedge cclk) begin
    if (lines.rd) begin
      for (int w = 0; w < cache_pkg::ways; w++) begin
        rd_lines[w] <= mem[lines.index][w];
      end
    end
  end

  // Way and word select after the read
  assign lines.rline = rd_lines[lines.way];
  assign lines.rword = lines.rline[lines.word_sel];

  ////////////////////////////////////////
  // Writes
  ////////////////////////////////////////
  always_ff @(posedge cclk) begin
    if (lines.wr_line) begin
      mem[lines.index][lines.way] <= lines.wline;  // Fill after a miss
    end else if (lines.wr_word) begin
      mem[lines.index][lines.way][lines.word_sel] <= lines.wdata;
    end
  end

endmodule

/* hdl/cache_ctrl.sv */
// Request access FSM, fill shift register, write-back counter and ack port
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                cclk,
  input  logic                cresetn,
  tag_if.ctrl                 tags,
  data_if.ctrl                lines,
  input  logic                req_valid,
  output logic                req_ready,
  input  cache_pkg::op_t      req_op,
  input  cache_pkg::word_t    req_address,
  input  cache_pkg::word_t    req_data,
  input  logic                req_last,
  output logic                ack_valid,
  input  logic                ack_ready,
  output cache_pkg::ack_t     ack_type,
  output logic                ack_hit,
  output cache_pkg::word_t    ack_address,
  output cache_pkg::word_t    ack_data,
  output logic                ack_last
);

  logic [cache_pkg::state_w-1:0]    state, state_nxt;
  cache_pkg::addr_u                 addr_q;
  cache_pkg::op_t                   op_q;
  cache_pkg::word_t                 data_q;
  cache_pkg::addr_u                 cur_addr;
  cache_pkg::addr_u                 line_addr;
  cache_pkg::addr_u                 victim_addr;
  cache_pkg::line_t                 fill_line;
  cache_pkg::line_t                 merge_line;
  logic [cache_pkg::word_sel_w-1:0] wb_cnt;
  cache_pkg::way_t                  way_sel;
  logic                             accept;
  logic                             fill_acc;
  logic                             is_write;
  logic                             ack_done;

  assign req_ready = req_valid &&
    ((state == cache_pkg::st_idle &&
      (req_op == cache_pkg::op_read || req_op == cache_pkg::op_write)) ||
     (state == cache_pkg::st_fill_wait && req_op == cache_pkg::op_fill));

  assign accept   = req_ready && state == cache_pkg::st_idle;
  assign fill_acc = req_ready && state == cache_pkg::st_fill_wait;
  assign is_write = op_q == cache_pkg::op_write;
  assign ack_done = ack_valid && ack_ready;

  ////////////////////////////////////////
  // Addresses
  ////////////////////////////////////////
  always_comb begin
    cur_addr.raw = (state == cache_pkg::st_idle) ? req_address : addr_q.raw;
    line_addr = addr_q;
    line_addr.f.word_sel = '0;
    line_addr.f.byte_off = '0;
    victim_addr = line_addr;
    victim_addr.f.tag = tags.victim_tag;
  end

  // Write word goes over the filled line
  always_comb begin
    merge_line = fill_line;
    if (is_write) merge_line[addr_q.f.word_sel] = data_q;
  end

  assign way_sel = tags.hit ? tags.hit_way : tags.victim_way;

  ////////////////////////////////////////
  // Array control
  ////////////////////////////////////////
  assign tags.lookup      = accept;
  assign tags.lookup_addr = cur_addr;
  assign tags.update      = state == cache_pkg::st_hit_ack && !ack_valid;
  assign tags.install     = state == cache_pkg::st_install;
  assign tags.update_way  = way_sel;
  assign tags.set_dirty   = is_write;

  assign lines.rd       = accept;
  assign lines.index    = cur_addr.f.index;
  assign lines.word_sel = cur_addr.f.word_sel;
  assign lines.way      = way_sel;
  assign lines.wr_word  = tags.update && is_write;
  assign lines.wr_line  = tags.install;
  assign lines.wdata    = data_q;
  assign lines.wline    = merge_line;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////
  always_ff @(posedge cclk or negedge cresetn) begin
    if (!cresetn) state <= cache_pkg::st_idle;
    else          state <= state_nxt;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      cache_pkg::st_idle:       if (accept) state_nxt = cache_pkg::st_lookup;
      cache_pkg::st_lookup: begin
        if (tags.hit)               state_nxt = cache_pkg::st_hit_ack;
        else if (tags.victim_dirty) state_nxt = cache_pkg::st_write_back;
        else                        state_nxt = cache_pkg::st_fetch;
      end
      cache_pkg::st_hit_ack:    if (ack_done) state_nxt = cache_pkg::st_idle;
      cache_pkg::st_write_back: if (ack_done && ack_last) state_nxt = cache_pkg::st_fetch;
      cache_pkg::st_fetch:      if (ack_done) state_nxt = cache_pkg::st_fill_wait;
      cache_pkg::st_fill_wait:  if (fill_acc && req_last) state_nxt = cache_pkg::st_install;
      cache_pkg::st_install:    state_nxt = cache_pkg::st_miss_ack;
      cache_pkg::st_miss_ack:   if (ack_done) state_nxt = cache_pkg::st_idle;
      default:                  state_nxt = cache_pkg::st_idle;
    endcase
  end

  always_ff @(posedge cclk) begin
    if (accept) begin
      addr_q.raw <= req_address;
      op_q       <= req_op;
      data_q     <= req_data;
    end
    if (fill_acc) fill_line <= {req_data, fill_line[cache_pkg::words_per_line-1:1]};
  end

  ////////////////////////////////////////
  // Ack port
  ////////////////////////////////////////
  always_ff @(posedge cclk or negedge cresetn) begin
    if (!cresetn) begin
      ack_valid   <= 1'b0;
      ack_type    <= cache_pkg::ack_fetch;
      ack_hit     <= 1'b0;
      ack_address <= '0;
      ack_data    <= '0;
      ack_last    <= 1'b0;
      wb_cnt      <= '0;
    end else begin
      case (state)
        cache_pkg::st_lookup: wb_cnt <= '0;
        cache_pkg::st_hit_ack: begin
          if (!ack_valid) begin
            ack_valid   <= 1'b1;
            ack_type    <= is_write ? cache_pkg::ack_write : cache_pkg::ack_read;
            ack_hit     <= 1'b1;
            ack_address <= addr_q.raw;
            ack_data    <= is_write ? data_q : lines.rword;
            ack_last    <= 1'b0;
          end else if (ack_ready) begin
            ack_valid <= 1'b0;
            ack_hit   <= 1'b0;
          end
        end
        cache_pkg::st_write_back: begin
          if (ack_done && ack_last) begin
            ack_valid <= 1'b0;
            ack_last  <= 1'b0;
          end else if (!ack_valid || ack_ready) begin
            ack_valid   <= 1'b1;
            ack_type    <= cache_pkg::ack_wb;
            ack_hit     <= 1'b0;
            ack_address <= victim_addr.raw;
            ack_data    <= lines.rline[wb_cnt];  // Word 0 first
            ack_last    <= wb_cnt == cache_pkg::word_sel_w'(cache_pkg::words_per_line - 1);
            wb_cnt      <= wb_cnt + 1'b1;
          end
        end
        cache_pkg::st_fetch: begin
          if (!ack_valid) begin
            ack_valid   <= 1'b1;
            ack_type    <= cache_pkg::ack_fetch;
            ack_hit     <= 1'b0;
            ack_address <= line_addr.raw;
            ack_last    <= 1'b0;
          end else if (ack_ready) begin
            ack_valid <= 1'b0;
          end
        end
        cache_pkg::st_install: begin
          ack_valid   <= 1'b1;
          ack_type    <= is_write ? cache_pkg::ack_write : cache_pkg::ack_read;
          ack_hit     <= 1'b0;
          ack_address <= addr_q.raw;
          ack_data    <= merge_line[addr_q.f.word_sel];
          ack_last    <= 1'b0;
        end
        cache_pkg::st_miss_ack: if (ack_ready) ack_valid <= 1'b0;
        default: ;
      endcase
    end
  end

endmodule

/* hdl/cache_4ways.sv */
// Cache top level joining the tag array, data array and controller
`timescale 1ns/1ps

module cache_4ways (
  input  logic                cclk,
  input  logic                cresetn,
  input  logic                req_valid,
  output logic                req_ready,
  input  cache_pkg::op_t      req_op,
  input  cache_pkg::word_t    req_address,
  input  cache_pkg::word_t    req_data,
  input  logic                req_last,     // Last fill word
  output logic                ack_valid,
  input  logic                ack_ready,
  output cache_pkg::ack_t     ack_type,
  output logic                ack_hit,
  output cache_pkg::word_t    ack_address,
  output cache_pkg::word_t    ack_data,
  output logic                ack_last      // Last write-back word
);

  tag_if  tag_bus ();
  data_if data_bus ();

  tag_array u_tag_array (
    .cclk    (cclk),
    .cresetn (cresetn),
    .tags    (tag_bus)
  );

  data_array u_data_array (
    .cclk  (cclk),
    .lines (data_bus)
  );

  cache_ctrl u_cache_ctrl (
    .cclk        (cclk),
    .cresetn     (cresetn),
    .tags        (tag_bus),
    .lines       (data_bus),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_op      (req_op),
    .req_address (req_address),
    .req_data    (req_data),
    .req_last    (req_last),
    .ack_valid   (ack_valid),
    .ack_ready   (ack_ready),
    .ack_type    (ack_type),
    .ack_hit     (ack_hit),
    .ack_address (ack_address),
    .ack_data    (ack_data),
    .ack_last    (ack_last)
  );

endmodule

/* test/cache_assertions.sv */
// Concurrent checks on the cache controller for hit way, ack stall and request ready
`timescale 1ns/1ps

module cache_assertions (
  input logic                          cclk,
  input logic                          cresetn,
  input logic [cache_pkg::state_w-1:0] state,
  input logic                          hit,
  input cache_pkg::way_t               hit_way,
  input logic                          req_ready,
  input logic                          ack_valid,
  input logic                          ack_ready,
  input logic [67:0]                   ack_bits   // Type, hit, address, data, last
);

  // The way found by the lookup holds through the hit ack
  assert property (@(posedge cclk) disable iff (!cresetn)
    (state == cache_pkg::st_hit_ack) |-> (hit && $stable(hit_way)))
    else $error("hit way lost or changed during a hit ack");

  // Every ack output holds while the receiver stalls
  assert property (@(posedge cclk) disable iff (!cresetn)
    (ack_valid && !ack_ready) |=> (ack_valid && $stable(ack_bits)))
    else $error("ack outputs changed during a stall");

  assert property (@(posedge cclk) disable iff (!cresetn)
    ack_valid |-> !req_ready)
    else $error("req_ready high while an ack is pending");

endmodule

/* test/cache_tb.sv */
// Cache testbench with clock, reset, vector driver, sparse memory model and checks
`timescale 1ns/1ps

module cache_tb;

  localparam int max_vec  = 32;
  localparam int fields   = 5;    // Words per vector line
  localparam int wait_max = 200;  // Cycles allowed in one wait loop

  logic             cclk;
  logic             cresetn;
  logic             req_valid;
  logic             req_ready;
  cache_pkg::op_t   req_op;
  cache_pkg::word_t req_address;
  cache_pkg::word_t req_data;
  logic             req_last;
  logic             ack_valid;
  logic             ack_ready;
  cache_pkg::ack_t  ack_type;
  logic             ack_hit;
  cache_pkg::word_t ack_address;
  cache_pkg::word_t ack_data;
  logic             ack_last;

  logic [31:0]      vec_mem [fields*max_vec];
  cache_pkg::word_t ref_mem [cache_pkg::word_t];      // Words written so far
  bit               dirty_lines [cache_pkg::word_t];  // Lines written since their fill
  logic [31:0]      lfsr;
  logic             stall_a, stall_b;
  int               edge_cnt = 0;
  int               vec_cnt;

  cache_4ways uut (.*);

  bind cache_ctrl cache_assertions u_assertions (
    .cclk      (cclk),
    .cresetn   (cresetn),
    .state     (state),
    .hit       (tags.hit),
    .hit_way   (tags.hit_way),
    .req_ready (req_ready),
    .ack_valid (ack_valid),
    .ack_ready (ack_ready),
    .ack_bits  ({ack_type, ack_hit, ack_address, ack_data, ack_last})
  );

  initial begin
    cclk = 1'b0;
    forever #20 cclk = ~cclk;
  end

  always @(posedge cclk) edge_cnt <= edge_cnt + 1;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  function automatic cache_pkg::word_t mem_read(input cache_pkg::word_t addr);
    cache_pkg::word_t a;
    a = {addr[31:2], 2'b00};
    if (ref_mem.exists(a)) return ref_mem[a];
    return a ^ 32'h5a5a0000;
  endfunction

  task automatic abort_run(input string why);
    $display("SOME TESTS FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      abort_run({"wrong value on ", name});
    end
  endtask

  task automatic drive_req(input logic valid, input cache_pkg::op_t op,
                           input cache_pkg::word_t addr, input cache_pkg::word_t data,
                           input logic last);
    @(posedge cclk);
    #2;
    req_valid   = valid;
    req_op      = op;
    req_address = addr;
    req_data    = data;
    req_last    = last;
  endtask

  // Returns at the falling edge before the accepting rising edge
  task automatic wait_req_ready(input string what);
    int n;
    n = 0;
    @(negedge cclk);
    while (!req_ready) begin
      n++;
      if (n > wait_max) abort_run({"the DUT did not accept a ", what, " in time"});
      @(negedge cclk);
    end
  endtask

  task automatic send_fill(input cache_pkg::word_t line);
    cache_pkg::word_t a;
    @(negedge cclk);
    check_value("req_ready", 32'(req_ready), 32'h0);  // Read held in FILL_WAIT
    for (int k = 0; k < cache_pkg::words_per_line; k++) begin
      a = line + 32'(4 * k);
      drive_req(1'b1, cache_pkg::op_fill, a, mem_read(a), k == cache_pkg::words_per_line - 1);
      wait_req_ready("fill word");
    end
    drive_req(1'b1, cache_pkg::op_read, line, '0, 1'b0);
  endtask

  ////////////////////////////////////////
  // One access with all of its ack beats
  ////////////////////////////////////////
  task automatic run_vector(input int n);
    cache_pkg::op_t   op;
    cache_pkg::word_t addr, wdata, exp_data, line, wb_line;
    logic             exp_hit;
    int               accept_edge, rise_edge, wb_beats, fetches, n_wait;
    bit               done;
    op        = vec_mem[n*fields][1:0];
    addr      = vec_mem[n*fields+1];
    wdata     = vec_mem[n*fields+2];
    exp_hit   = vec_mem[n*fields+3][0];
    exp_data  = vec_mem[n*fields+4];
    line      = {addr[31:4], 4'h0};
    wb_line   = '0;
    rise_edge = -1;
    wb_beats  = 0;
    fetches   = 0;
    n_wait    = 0;
    done      = 1'b0;
    if (op == cache_pkg::op_read) check_value("vector read data", exp_data, mem_read(addr));
    drive_req(1'b1, op, addr, wdata, 1'b0);
    wait_req_ready("request");
    accept_edge = edge_cnt + 1;
    // A further read stays presented while the access is busy
    drive_req(1'b1, cache_pkg::op_read, addr, wdata, 1'b0);
    while (!done) begin
      @(negedge cclk);
      n_wait++;
      if (n_wait > wait_max) abort_run("no final ack from the DUT in time");
      check_value("req_ready", 32'(req_ready), 32'h0);
      if (ack_valid && rise_edge < 0) rise_edge = edge_cnt;
      if (ack_valid && ack_ready) begin
        case (ack_type)
          cache_pkg::ack_wb: begin
            if (wb_beats == 0) begin
              wb_line = ack_address;
              if (!dirty_lines.exists(wb_line)) abort_run("write-back of a clean line");
              check_value("wb index", 32'(wb_line[7:0]), 32'({addr[7:4], 4'h0}));
            end
            if (wb_beats > 3) abort_run("more than four write-back beats");
            check_value("ack_address", ack_address, wb_line);
            check_value("ack_data", ack_data, mem_read(wb_line + 32'(4 * wb_beats)));
            check_value("ack_last", 32'(ack_last), 32'(wb_beats == 3));
            wb_beats++;
            if (wb_beats == 4) dirty_lines.delete(wb_line);
          end
          cache_pkg::ack_fetch: begin
            if (exp_hit) abort_run("line fetch for an access that should hit");
            if (wb_beats != 0 && wb_beats != 4) abort_run("fetch before the write-back ended");
            if (dirty_lines.exists(line)) abort_run("a written line was lost without write-back");
            check_value("ack_address", ack_address, line);
            check_value("ack_last", 32'(ack_last), 32'h0);
            fetches++;
            send_fill(line);
          end
          default: begin
            if (fetches != (exp_hit ? 0 : 1)) abort_run("wrong number of fetches for the access");
            check_value("ack_type", 32'(ack_type), (op == cache_pkg::op_write) ?
                        32'(cache_pkg::ack_write) : 32'(cache_pkg::ack_read));
            check_value("ack_hit", 32'(ack_hit), 32'(exp_hit));
            check_value("ack_address", ack_address, addr);
            check_value("ack_data", ack_data, exp_data);
            check_value("ack_last", 32'(ack_last), 32'h0);
            if (exp_hit) check_value("hit ack edges", 32'(rise_edge - accept_edge), 32'd2);
            done = 1'b1;
          end
        endcase
      end
    end
    if (op == cache_pkg::op_write) begin
      ref_mem[{addr[31:2], 2'b00}] = wdata;
      dirty_lines[line] = 1'b1;
    end
  endtask

  // Receiver stalls on a quarter of the cycles
  initial begin
    ack_ready = 1'b0;
    lfsr      = 32'ha152ce92;
    forever begin
      @(posedge cclk);
      #2;
      lfsr      = lfsr_next(lfsr);
      stall_a   = lfsr[0];
      lfsr      = lfsr_next(lfsr);
      stall_b   = lfsr[0];
      ack_ready = !(stall_a && stall_b);
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    cresetn     = 1'b0;
    req_valid   = 1'b0;
    req_op      = cache_pkg::op_read;
    req_address = '0;
    req_data    = '0;
    req_last    = 1'b0;
    vec_cnt     = 0;
    for (int i = 0; i < fields * max_vec; i++) vec_mem[i] = '0;
    $readmemh("test/cache_vectors.txt", vec_mem);
    repeat (10) @(posedge cclk);
    #2;
    cresetn   = 1'b1;
    req_valid = 1'b1;  // Fill word presented in IDLE
    req_op    = cache_pkg::op_fill;
    @(negedge cclk);
    check_value("ack_valid", 32'(ack_valid), 32'h0);
    check_value("req_ready", 32'(req_ready), 32'h0);
    while (vec_cnt < max_vec && vec_mem[vec_cnt*fields] != '0) begin
      run_vector(vec_cnt);
      vec_cnt++;
    end
    if (vec_cnt == 0) begin
      abort_run("no vectors were read from the vector file");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

/* cache_4ways.f */
hdl/cache_pkg.sv
hdl/cache_ifs.sv
hdl/tag_array.sv
hdl/data_array.sv
hdl/cache_ctrl.sv
hdl/cache_4ways.sv
test/cache_assertions.sv
test/cache_tb.sv

/* Makefile */
TOP := cache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f cache_4ways.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f cache_4ways.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* test/cache_vectors.txt */
// op (1 read, 2 write), address, write data, expected hit, expected read data
// Set 3 gets five and more tags to force LRU evictions and write-backs
1 00010030 00000000 0 5a5b0030
1 00010038 00000000 1 5a5b0038
2 00010034 11112222 1 11112222
1 00010034 00000000 1 11112222
1 00010030 00000000 1 5a5b0030
1 0001003c 00000000 1 5a5b003c
1 00020030 00000000 0 5a580030
1 00030034 00000000 0 5a590034
1 0004003c 00000000 0 5a5e003c
1 00020034 00000000 1 5a580034
1 00050030 00000000 0 5a5f0030
1 00010034 00000000 0 11112222
1 0002003c 00000000 1 5a58003c
1 00040030 00000000 1 5a5e0030
1 00050034 00000000 1 5a5f0034
1 00030030 00000000 0 5a590030
2 00060038 cafe0001 0 cafe0001
1 00060038 00000000 1 cafe0001
1 0006003c 00000000 1 5a5c003c
2 00050030 0badf00d 1 0badf00d
1 00070030 00000000 0 5a5d0030
1 00080030 00000000 0 5a520030
1 00090030 00000000 0 5a530030
1 00060038 00000000 0 cafe0001
1 12345674 00000000 0 486e5674
1 12345670 00000000 1 486e5670
2 12345678 00c0ffee 1 00c0ffee
1 12345678 00000000 1 00c0ffee
